// File: hdl/wtm32_consts.svh
`ifndef WTM32_CONSTS_SVH
`define WTM32_CONSTS_SVH

// operand and product widths
`define WTM_OP_W 32
`define WTM_PROD_W 64

// one partial-product row per multiplier bit
`define WTM_ROWS 32

// carry-save levels, 32 rows down to 2
`define WTM_LEVELS 8

// result slots granted by the consumer
`define WTM_CREDITS 4

// accept to result in cycles
`define WTM_LATENCY 11

`endif

// File: hdl/wtm32_pkg.sv
`default_nettype none

`include "wtm32_consts.svh"

package wtm32_pkg;

  // one partial-product or carry-save row
  typedef logic [`WTM_PROD_W-1:0] row_t;

  // a 64-bit word, whole or split into its two 32-bit halves
  typedef union packed {
    logic [`WTM_PROD_W-1:0] word;
    struct packed {
      logic [`WTM_OP_W-1:0] hi;
      logic [`WTM_OP_W-1:0] lo;
    } halves;
  } product_t;

endpackage

`default_nettype wire

// File: hdl/pp_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "wtm32_consts.svh"

module pp_gen (
  input  wire logic                                clk,
  input  wire logic                                arst_n,
  input  wire logic                                valid,
  input  wire logic [`WTM_OP_W-1:0]                a,
  input  wire logic [`WTM_OP_W-1:0]                b,
  output logic                                     pp_valid,
  output wtm32_pkg::row_t [`WTM_ROWS-1:0]          rows
);

  wtm32_pkg::row_t [`WTM_ROWS-1:0] pp;

  // row i is b masked by a[i], placed at weight 2^i
  always_comb begin
    for (int i = 0; i < `WTM_ROWS; i++) begin
      pp[i] = {{(`WTM_PROD_W-`WTM_OP_W){1'b0}}, b & {`WTM_OP_W{a[i]}}} << i;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= valid;
    end
  end

  always_ff @(posedge clk) begin
    rows <= pp;
  end

endmodule

`default_nettype wire

// File: hdl/csa_level.sv
`timescale 1ns/10ps
`default_nettype none

module csa_level #(
  parameter  int rows_in  = 3,
  localparam int rows_out = 2 * (rows_in / 3) + (rows_in % 3)
) (
  input  wire logic                              clk,
  input  wire logic                              arst_n,
  input  wire logic                              in_valid,
  input  wire wtm32_pkg::row_t [rows_in-1:0]     in_rows,
  output logic                                   out_valid,
  output wtm32_pkg::row_t [rows_out-1:0]         out_rows
);

  localparam int groups = rows_in / 3;
  localparam int rem    = rows_in % 3;

  wtm32_pkg::row_t [rows_out-1:0] nxt_rows;

  // 3:2 compression per group of three rows
  for (genvar g = 0; g < groups; g++) begin : g_group
    wtm32_pkg::row_t x;
    wtm32_pkg::row_t y;
    wtm32_pkg::row_t z;

    assign x = in_rows[3*g];
    assign y = in_rows[3*g+1];
    assign z = in_rows[3*g+2];

    assign nxt_rows[2*g]   = x ^ y ^ z;
    // majority moves up one weight
    assign nxt_rows[2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
  end

  // leftover rows ride along to the next level
  for (genvar r = 0; r < rem; r++) begin : g_pass
    assign nxt_rows[2*groups+r] = in_rows[3*groups+r];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_rows <= nxt_rows;
  end

endmodule

`default_nettype wire

// File: hdl/wallace_tree.sv
`timescale 1ns/10ps
`default_nettype none

`include "wtm32_consts.svh"

module wallace_tree (
  input  wire logic                               clk,
  input  wire logic                               arst_n,
  input  wire logic                               in_valid,
  input  wire wtm32_pkg::row_t [`WTM_ROWS-1:0]    rows,
  output logic                                    sum_valid,
  output wtm32_pkg::row_t                         sum_row,
  output wtm32_pkg::row_t                         carry_row
);

  // valid bit per level boundary
  logic [`WTM_LEVELS:0] lvl_valid;

  wtm32_pkg::row_t [21:0] l1_rows;
  wtm32_pkg::row_t [14:0] l2_rows;
  wtm32_pkg::row_t [9:0]  l3_rows;
  wtm32_pkg::row_t [6:0]  l4_rows;
  wtm32_pkg::row_t [4:0]  l5_rows;
  wtm32_pkg::row_t [3:0]  l6_rows;
  wtm32_pkg::row_t [2:0]  l7_rows;
  wtm32_pkg::row_t [1:0]  l8_rows;

  assign lvl_valid[0] = in_valid;

  csa_level #(.rows_in(32)) u_lvl1 (
    .clk(clk), .arst_n(arst_n), .in_valid(lvl_valid[0]), .in_rows(rows),
    .out_valid(lvl_valid[1]), .out_rows(l1_rows));

  csa_level #(.rows_in(22)) u_lvl2 (
    .clk(clk), .arst_n(arst_n), .in_valid(lvl_valid[1]), .in_rows(l1_rows),
    .out_valid(lvl_valid[2]), .out_rows(l2_rows));

  csa_level #(.rows_in(15)) u_lvl3 (
    .clk(clk), .arst_n(arst_n), .in_valid(lvl_valid[2]), .in_rows(l2_rows),
    .out_valid(lvl_valid[3]), .out_rows(l3_rows));

  csa_level #(.rows_in(10)) u_lvl4 (
    .clk(clk), .arst_n(arst_n), .in_valid(lvl_valid[3]), .in_rows(l3_rows),
    .out_valid(lvl_valid[4]), .out_rows(l4_rows));

  csa_level #(.rows_in(7)) u_lvl5 (
    .clk(clk), .arst_n(arst_n), .in_valid(lvl_valid[4]), .in_rows(l4_rows),
    .out_valid(lvl_valid[5]), .out_rows(l5_rows));

  csa_level #(.rows_in(5)) u_lvl6 (
    .clk(clk), .arst_n(arst_n), .in_valid(lvl_valid[5]), .in_rows(l5_rows),
    .out_valid(lvl_valid[6]), .out_rows(l6_rows));

  csa_level #(.rows_in(4)) u_lvl7 (
    .clk(clk), .arst_n(arst_n), .in_valid(lvl_valid[6]), .in_rows(l6_rows),
    .out_valid(lvl_valid[7]), .out_rows(l7_rows));

  csa_level #(.rows_in(3)) u_lvl8 (
    .clk(clk), .arst_n(arst_n), .in_valid(lvl_valid[7]), .in_rows(l7_rows),
    .out_valid(lvl_valid[8]), .out_rows(l8_rows));

  // last level leaves sum in row 0, shifted carry in row 1
  assign sum_valid = lvl_valid[`WTM_LEVELS];
  assign sum_row   = l8_rows[0];
  assign carry_row = l8_rows[1];

endmodule

`default_nettype wire

// File: hdl/final_adder.sv
`timescale 1ns/10ps
`default_nettype none

`include "wtm32_consts.svh"

module final_adder (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 in_valid,
  input  wire wtm32_pkg::row_t      sum_row,
  input  wire wtm32_pkg::row_t      carry_row,
  output logic                      out_valid,
  output wtm32_pkg::product_t       product
);

  wtm32_pkg::product_t sum_w;
  wtm32_pkg::product_t carry_w;

  logic [`WTM_OP_W:0]   lo_full;
  logic                 mid_valid;
  logic [`WTM_OP_W-1:0] lo_sum_q;
  logic                 lo_carry_q;
  logic [`WTM_OP_W-1:0] sum_hi_q;
  logic [`WTM_OP_W-1:0] carry_hi_q;

  assign sum_w.word   = sum_row;
  assign carry_w.word = carry_row;

  // low half, carry out in the top bit
  assign lo_full = {1'b0, sum_w.halves.lo} + {1'b0, carry_w.halves.lo};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mid_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      mid_valid <= in_valid;
      out_valid <= mid_valid;
    end
  end

  // stage 1: low sum and carry, high halves held for the next cycle
  always_ff @(posedge clk) begin
    lo_sum_q   <= lo_full[`WTM_OP_W-1:0];
    lo_carry_q <= lo_full[`WTM_OP_W];
    sum_hi_q   <= sum_w.halves.hi;
    carry_hi_q <= carry_w.halves.hi;
  end

  // stage 2: high half plus carry; overflow past bit 63 is dropped
  always_ff @(posedge clk) begin
    product.halves.hi <= sum_hi_q + carry_hi_q + {{(`WTM_OP_W-1){1'b0}}, lo_carry_q};
    product.halves.lo <= lo_sum_q;
  end

endmodule

`default_nettype wire

// File: hdl/credit_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "wtm32_consts.svh"

module credit_ctrl (
  input  wire logic clk,
  input  wire logic arst_n,
  input  wire logic in_valid,
  input  wire logic credit_ret,
  output logic      in_ready,
  output logic      accept
);

  localparam int cnt_w = $clog2(`WTM_CREDITS + 1);

  logic [cnt_w-1:0] credits;

  assign in_ready = (credits != '0);
  assign accept   = in_valid & in_ready;

  // take one on accept, give one back per return pulse
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= cnt_w'(`WTM_CREDITS);
    end else begin
      case ({accept, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/wtm32.sv
`timescale 1ns/10ps
`default_nettype none

`include "wtm32_consts.svh"

module wtm32 (
  input  wire logic                   clk,
  input  wire logic                   arst_n,

  input  wire logic                   in_valid,
  input  wire logic [`WTM_OP_W-1:0]   in_a,
  input  wire logic [`WTM_OP_W-1:0]   in_b,
  output logic                        in_ready,

  output logic                        out_valid,
  output logic [`WTM_PROD_W-1:0]      out_product,
  input  wire logic                   credit_ret
);

  logic                            accept;
  logic                            pp_valid;
  wtm32_pkg::row_t [`WTM_ROWS-1:0] pp_rows;
  logic                            sum_valid;
  wtm32_pkg::row_t                 sum_row;
  wtm32_pkg::row_t                 carry_row;
  wtm32_pkg::product_t             product;

  credit_ctrl u_credit_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .credit_ret (credit_ret),
    .in_ready   (in_ready),
    .accept     (accept)
  );

  // accept doubles as the valid bit entering the pipeline
  pp_gen u_pp_gen (
    .clk      (clk),
    .arst_n   (arst_n),
    .valid    (accept),
    .a        (in_a),
    .b        (in_b),
    .pp_valid (pp_valid),
    .rows     (pp_rows)
  );

  wallace_tree u_wallace_tree (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (pp_valid),
    .rows      (pp_rows),
    .sum_valid (sum_valid),
    .sum_row   (sum_row),
    .carry_row (carry_row)
  );

  final_adder u_final_adder (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (sum_valid),
    .sum_row   (sum_row),
    .carry_row (carry_row),
    .out_valid (out_valid),
    .product   (product)
  );

  assign out_product = product.word;

endmodule

`default_nettype wire

// File: bench/wtm32_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "wtm32_consts.svh"

module wtm32_asserts (
  input wire logic clk,
  input wire logic arst_n,
  input wire logic in_valid,
  input wire logic in_ready,
  input wire logic accept,
  input wire logic out_valid,
  input wire logic credit_ret
);

  logic failed = 1'b0;
  int   outstanding;

  // accepts not yet paid back by credit_ret
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(accept) - int'(credit_ret);
    end
  end

  // accept exactly when a request meets a free credit
  a_accept_rule: assert property (@(posedge clk) disable iff (!arst_n)
    accept == (in_valid && (outstanding < `WTM_CREDITS)))
  else begin
    $error("accept does not match in_valid and the free credits");
    failed = 1'b1;
  end

  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(accept, `WTM_LATENCY))
  else begin
    $error("out_valid not exactly %0d cycles after an accept", `WTM_LATENCY);
    failed = 1'b1;
  end

  a_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
    outstanding >= 0 && outstanding <= `WTM_CREDITS)
  else begin
    $error("outstanding count %0d out of range", outstanding);
    failed = 1'b1;
  end

  // ready only while a credit is left
  a_ready_credit: assert property (@(posedge clk) disable iff (!arst_n)
    in_ready == (outstanding < `WTM_CREDITS))
  else begin
    $error("in_ready wrong for %0d outstanding", outstanding);
    failed = 1'b1;
  end

  a_reset_exit: assert property (@(posedge clk)
    $rose(arst_n) |-> (!out_valid && in_ready))
  else begin
    $error("bad out_valid or in_ready right after reset");
    failed = 1'b1;
  end

endmodule

bind wtm32 wtm32_asserts u_asserts (
  .clk        (clk),
  .arst_n     (arst_n),
  .in_valid   (in_valid),
  .in_ready   (in_ready),
  .accept     (accept),
  .out_valid  (out_valid),
  .credit_ret (credit_ret)
);

`default_nettype wire

// File: bench/wtm32_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "wtm32_consts.svh"

module wtm32_tb;

  // about 2000 cycles of credit-limited traffic
  localparam int max_cycles = 5000;

  localparam int drain_random = 0;
  localparam int drain_fast   = 1;
  localparam int drain_hold   = 2;

  logic                   clk;
  logic                   arst_n;
  logic                   in_valid;
  logic [`WTM_OP_W-1:0]   in_a;
  logic [`WTM_OP_W-1:0]   in_b;
  logic                   in_ready;
  logic                   out_valid;
  logic [`WTM_PROD_W-1:0] out_product;
  logic                   credit_ret = 1'b0;

  integer seed = 46;
  int     cycle_cnt;
  int     drain_mode;
  int     sink_fill;
  int     drain_wait;

  logic [`WTM_PROD_W-1:0] expect_q [$];

  logic [`WTM_OP_W-1:0] corner_a [10] = '{32'h0, 32'h0, 32'h1, 32'h1, 32'hffffffff,
    32'haaaaaaaa, 32'h55555555, 32'haaaaaaaa, 32'h80000000, 32'hffffffff};
  logic [`WTM_OP_W-1:0] corner_b [10] = '{32'h0, 32'hffffffff, 32'h1, 32'hffffffff,
    32'hffffffff, 32'h55555555, 32'haaaaaaaa, 32'haaaaaaaa, 32'h80000000, 32'h2};

  wtm32 u_wtm32 (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_a        (in_a),
    .in_b        (in_b),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_product (out_product),
    .credit_ret  (credit_ret)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [`WTM_OP_W-1:0] rand_word();
    return $random(seed);
  endfunction

  task automatic idle_cycles(input int n);
    in_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  // returns on the accepting edge
  task automatic send_pair(input logic [`WTM_OP_W-1:0] a, input logic [`WTM_OP_W-1:0] b);
    in_valid <= 1'b1;
    in_a     <= a;
    in_b     <= b;
    do begin
      @(negedge clk);
    end while (!in_ready);
    @(posedge clk);
  endtask

  // sink buffer, one credit back per drained entry
  always @(posedge clk) begin
    int fill;
    if (!arst_n) begin
      sink_fill  <= 0;
      drain_wait <= 0;
      credit_ret <= 1'b0;
    end else begin
      fill = sink_fill + (out_valid ? 1 : 0);
      credit_ret <= 1'b0;
      if (drain_mode != drain_hold && fill > 0) begin
        if (drain_wait == 0) begin
          credit_ret <= 1'b1;
          fill = fill - 1;
          // gap before the next drain
          drain_wait <= (drain_mode == drain_random) ? $unsigned($random(seed)) % 7 : 0;
        end else begin
          drain_wait <= drain_wait - 1;
        end
      end
      sink_fill <= fill;
    end
  end

  // scoreboard
  always @(posedge clk) begin
    logic [`WTM_PROD_W-1:0] wide_a;
    logic [`WTM_PROD_W-1:0] wide_b;
    logic [`WTM_PROD_W-1:0] expected;
    wide_a = in_a;
    wide_b = in_b;
    if (arst_n && in_valid && in_ready) begin
      expect_q.push_back(wide_a * wide_b);
    end
    if (arst_n && out_valid) begin
      if (expect_q.size() == 0) begin
        abort_run("a result came out with no accepted operand pair waiting");
      end else begin
        expected = expect_q.pop_front();
        assert (out_product == expected) else begin
          abort_run($sformatf("CHECK FAILED at %0t: product %h, expected %h",
                              $time, out_product, expected));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (u_wtm32.u_asserts.failed) begin
      abort_run($sformatf("CHECK FAILED at %0t: a bound assertion in wtm32_asserts fired",
                          $time));
    end else if (cycle_cnt >= max_cycles) begin
      abort_run($sformatf("timeout: the run did not finish within %0d cycles", max_cycles));
    end
  end

  initial begin
    int gap;
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_a       = '0;
    in_b       = '0;
    drain_mode = drain_fast;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // quiet window, nothing may come out
    idle_cycles(20);

    for (int i = 0; i < 10; i++) begin
      send_pair(corner_a[i], corner_b[i]);
    end
    idle_cycles(15);

    // back to back burst with credits returned at once
    repeat (8) send_pair(rand_word(), rand_word());
    idle_cycles(15);

    // hold credits, in_ready must drop after four accepts
    drain_mode <= drain_hold;
    fork
      repeat (6) send_pair(rand_word(), rand_word());
      begin
        repeat (40) @(posedge clk);
        drain_mode <= drain_random;
      end
    join

    drain_mode <= drain_random;
    for (int i = 0; i < 500; i++) begin
      if (($random(seed) & 3) == 0) begin
        gap = $unsigned($random(seed)) % 3 + 1;
        idle_cycles(gap);
      end
      send_pair(rand_word(), rand_word());
    end
    idle_cycles(1);

    while (expect_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);

    if (u_wtm32.u_asserts.failed) begin
      abort_run("a bound assertion in wtm32_asserts fired near the end of the run");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: wtm32.f
+incdir+hdl
hdl/wtm32_pkg.sv
hdl/pp_gen.sv
hdl/csa_level.sv
hdl/wallace_tree.sv
hdl/final_adder.sv
hdl/credit_ctrl.sv
hdl/wtm32.sv
bench/wtm32_asserts.sv
bench/wtm32_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the wtm32 testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module wtm32_tb -f wtm32.f -o wtm32_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/wtm32_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Some tests failed" "$log"; then
  echo "simulation failed"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

echo "simulation passed"
exit 0
